//--- logic/cpu_pkg.sv
// cpu package with widths, instruction encodings, FSM states and the decoded instruction
package cpu_pkg;

    localparam int word_width = 16;
    localparam int reg_count = 8;

    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
    typedef logic [word_width-1:0] word_t;

    typedef enum logic [2:0] {
        op_ldr  = 3'b011,
        op_str  = 3'b100,
        op_alu  = 3'b101,
        op_move = 3'b110,
        op_halt = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add   = 2'b00,
        alu_sub   = 2'b01,
        alu_and   = 2'b10,
        alu_not_b = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        sh_none        = 2'b00,
        sh_left        = 2'b01,
        sh_right_logic = 2'b10,
        sh_right_arith = 2'b11
    } shift_e;

    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_read  = 2'b01,
        mem_write = 2'b10
    } mem_cmd_e;

    typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_imm8, wb_mdata} wb_sel_e;

    typedef enum logic [4:0] {
        st_reset, st_fetch_addr, st_fetch_load, st_update_pc,
        st_write_imm, st_get_a, st_get_b, st_alu, st_write_rd,
        st_addr_calc, st_load_addr, st_load_wait, st_write_mdata,
        st_get_rd, st_store, st_store_hold, st_halt
    } cpu_state_e;

    typedef struct packed {
        opcode_e opcode;
        logic [1:0] op;
        alu_op_e alu_op;
        shift_e shift;
        reg_idx_t rn;
        reg_idx_t rd;
        reg_idx_t rm;
        word_t sximm5;
        word_t sximm8;
    } decoded_t;

endpackage

//--- logic/ctrl_if.sv
// control strobes and selects from the sequencer to the datapath
`timescale 1ns/1ns
interface ctrl_if;
    import cpu_pkg::*;

    logic load_a;
    logic load_b;
    logic load_c;
    logic reg_write;
    reg_sel_e reg_sel;      // register file index source
    wb_sel_e wb_sel;        // write-back source
    logic a_zero;
    logic b_imm5;
    logic load_pc;
    logic pc_clear;
    logic load_addr;
    logic addr_from_pc;     // memory address mux

    modport sequencer (
        output load_a, load_b, load_c, reg_write, reg_sel, wb_sel,
        output a_zero, b_imm5, load_pc, pc_clear, load_addr, addr_from_pc
    );

    modport datapath (
        input load_a, load_b, load_c, reg_write, reg_sel, wb_sel,
        input a_zero, b_imm5, load_pc, pc_clear, load_addr, addr_from_pc
    );
endinterface

//--- logic/instruction_decoder.sv
// instruction decoder holding the instruction register and splitting it into fields
`timescale 1ns/1ns
module instruction_decoder (
    input  logic clk,
    input  logic reset,
    input  logic load_ir,
    input  cpu_pkg::word_t read_data,
    output cpu_pkg::decoded_t dec
);
    import cpu_pkg::*;

    word_t ir;
    opcode_e opcode;
    logic is_mem;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (load_ir) begin
            ir <= read_data;
        end
    end

    assign opcode = opcode_e'(ir[15:13]);
    assign is_mem = (opcode == op_ldr) || (opcode == op_str);

    always_comb begin
        dec.opcode = opcode;
        dec.op = ir[12:11];
        dec.rn = ir[10:8];
        dec.rd = ir[7:5];
        dec.rm = ir[2:0];

        // address add for loads and stores
        if (is_mem) begin
            dec.alu_op = alu_add;
        end else begin
            dec.alu_op = alu_op_e'(ir[12:11]);
        end

        // store data passes through unshifted
        if (opcode == op_str) begin
            dec.shift = sh_none;
        end else begin
            dec.shift = shift_e'(ir[4:3]);
        end

        dec.sximm5 = {{(word_width - 5){ir[4]}}, ir[4:0]};
        dec.sximm8 = {{(word_width - 8){ir[7]}}, ir[7:0]};
    end
endmodule

//--- logic/control_sequencer.sv
// control sequencer stepping each instruction through fetch, execute and memory states
`timescale 1ns/1ns
module control_sequencer (
    input  logic clk,
    input  logic reset,
    input  cpu_pkg::decoded_t dec,
    ctrl_if.sequencer ctrl,
    output logic load_ir,
    output cpu_pkg::mem_cmd_e mem_cmd,
    output logic halted
);
    import cpu_pkg::*;

    cpu_state_e state;
    cpu_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_reset:      state_next = st_fetch_addr;
            st_fetch_addr: state_next = st_fetch_load;
            st_fetch_load: state_next = st_update_pc;
            st_update_pc: begin
                case (dec.opcode)
                    op_move: state_next = (dec.op == 2'b10) ? st_write_imm : st_get_b;
                    op_alu:  state_next = (dec.op == 2'b01) ? st_fetch_addr : st_get_a;
                    op_ldr:  state_next = st_get_a;
                    op_str:  state_next = st_get_a;
                    op_halt: state_next = st_halt;
                    default: state_next = st_fetch_addr;  // unsupported, skip
                endcase
            end
            st_write_imm:  state_next = st_fetch_addr;
            st_get_a: begin
                if (dec.opcode == op_ldr || dec.opcode == op_str) begin
                    state_next = st_addr_calc;
                end else begin
                    state_next = st_get_b;
                end
            end
            st_get_b:       state_next = st_alu;
            st_alu:         state_next = st_write_rd;
            st_write_rd:    state_next = st_fetch_addr;
            st_addr_calc:   state_next = st_load_addr;
            st_load_addr:   state_next = (dec.opcode == op_str) ? st_get_rd : st_load_wait;
            st_load_wait:   state_next = st_write_mdata;
            st_write_mdata: state_next = st_fetch_addr;
            st_get_rd:      state_next = st_store;
            st_store:       state_next = st_store_hold;
            st_store_hold:  state_next = st_fetch_addr;
            st_halt:        state_next = st_halt;
            default:        state_next = st_reset;
        endcase
    end

    always_comb begin
        ctrl.load_a = 1'b0;
        ctrl.load_b = 1'b0;
        ctrl.load_c = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.reg_sel = sel_rn;
        ctrl.wb_sel = wb_alu;
        ctrl.a_zero = 1'b0;
        ctrl.b_imm5 = 1'b0;
        ctrl.load_pc = 1'b0;
        ctrl.pc_clear = 1'b0;
        ctrl.load_addr = 1'b0;
        ctrl.addr_from_pc = 1'b0;
        load_ir = 1'b0;
        mem_cmd = mem_none;
        halted = 1'b0;

        case (state)
            st_reset: begin
                ctrl.load_pc = 1'b1;
                ctrl.pc_clear = 1'b1;
            end
            st_fetch_addr: begin
                mem_cmd = mem_read;
                ctrl.addr_from_pc = 1'b1;
            end
            st_fetch_load: begin
                mem_cmd = mem_read;
                ctrl.addr_from_pc = 1'b1;
                load_ir = 1'b1;
            end
            st_update_pc:  ctrl.load_pc = 1'b1;
            st_write_imm: begin
                ctrl.wb_sel = wb_imm8;
                ctrl.reg_write = 1'b1;    // rn gets sximm8
            end
            st_get_a:      ctrl.load_a = 1'b1;
            st_get_b: begin
                ctrl.reg_sel = sel_rm;
                ctrl.load_b = 1'b1;
            end
            st_alu: begin
                ctrl.load_c = 1'b1;
                ctrl.a_zero = (dec.opcode == op_move);  // mov reg is 0 + shifted b
            end
            st_write_rd: begin
                ctrl.reg_sel = sel_rd;
                ctrl.reg_write = 1'b1;
            end
            st_addr_calc: begin
                ctrl.b_imm5 = 1'b1;
                ctrl.load_c = 1'b1;
            end
            st_load_addr:  ctrl.load_addr = 1'b1;
            st_load_wait:  mem_cmd = mem_read;  // address settles
            st_write_mdata: begin
                mem_cmd = mem_read;
                ctrl.reg_sel = sel_rd;
                ctrl.wb_sel = wb_mdata;
                ctrl.reg_write = 1'b1;
            end
            st_get_rd: begin
                ctrl.reg_sel = sel_rd;
                ctrl.load_b = 1'b1;
            end
            st_store: begin
                ctrl.a_zero = 1'b1;
                ctrl.load_c = 1'b1;       // c becomes store data
            end
            st_store_hold: mem_cmd = mem_write;
            st_halt:       halted = 1'b1;
            default:       ;
        endcase
    end
endmodule

//--- logic/datapath.sv
// datapath with register file, operand registers, shifter, ALU, program counter and address
`timescale 1ns/1ns
module datapath #(
    parameter int addr_width = 9
) (
    input  logic clk,
    input  logic reset,
    input  cpu_pkg::decoded_t dec,
    ctrl_if.datapath ctrl,
    input  cpu_pkg::word_t read_data,
    output logic [addr_width-1:0] mem_addr,
    output cpu_pkg::word_t write_data
);
    import cpu_pkg::*;

    word_t regs [reg_count];
    reg_idx_t reg_idx;
    word_t wb_data;
    word_t a_reg;
    word_t b_reg;
    word_t c_reg;
    word_t b_shifted;
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] data_addr;

    always_comb begin
        case (ctrl.reg_sel)
            sel_rd:  reg_idx = dec.rd;
            sel_rm:  reg_idx = dec.rm;
            default: reg_idx = dec.rn;
        endcase

        case (ctrl.wb_sel)
            wb_imm8:  wb_data = dec.sximm8;
            wb_mdata: wb_data = read_data;
            default:  wb_data = c_reg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.reg_write) begin
            regs[reg_idx] <= wb_data;   // write index follows read index
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_a) begin
            a_reg <= regs[reg_idx];
        end
        if (ctrl.load_b) begin
            b_reg <= regs[reg_idx];
        end
        if (ctrl.load_c) begin
            c_reg <= alu_out;
        end
    end

    always_comb begin
        case (dec.shift)
            sh_left:        b_shifted = {b_reg[word_width-2:0], 1'b0};
            sh_right_logic: b_shifted = {1'b0, b_reg[word_width-1:1]};
            sh_right_arith: b_shifted = {b_reg[word_width-1], b_reg[word_width-1:1]};
            default:        b_shifted = b_reg;
        endcase

        alu_a = ctrl.a_zero ? '0 : a_reg;
        alu_b = ctrl.b_imm5 ? dec.sximm5 : b_shifted;

        case (dec.alu_op)
            alu_sub: alu_out = alu_a - alu_b;
            alu_and: alu_out = alu_a & alu_b;
            alu_not_b: alu_out = ~alu_b;
            default: alu_out = alu_a + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            data_addr <= '0;
        end else begin
            if (ctrl.load_pc) begin
                pc <= ctrl.pc_clear ? '0 : pc + 1'b1;
            end
            if (ctrl.load_addr) begin
                data_addr <= c_reg[addr_width-1:0];  // low bits of the sum
            end
        end
    end

    assign mem_addr = ctrl.addr_from_pc ? pc : data_addr;
    assign write_data = c_reg;
endmodule

//--- logic/cpu_top.sv
// multicycle 16-bit load/store cpu top level
`timescale 1ns/1ns
module cpu_top #(
    parameter int addr_width = 9
) (
    input  logic clk,
    input  logic reset,
    input  cpu_pkg::word_t read_data,
    output cpu_pkg::mem_cmd_e mem_cmd,
    output logic [addr_width-1:0] mem_addr,
    output cpu_pkg::word_t write_data,
    output logic halted
);
    import cpu_pkg::*;

    decoded_t dec;
    logic load_ir;

    ctrl_if ctrl_bus ();

    instruction_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .load_ir   (load_ir),
        .read_data (read_data),
        .dec       (dec)
    );

    control_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .dec     (dec),
        .ctrl    (ctrl_bus.sequencer),
        .load_ir (load_ir),
        .mem_cmd (mem_cmd),
        .halted  (halted)
    );

    datapath #(
        .addr_width (addr_width)
    ) u_datapath (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .ctrl       (ctrl_bus.datapath),
        .read_data  (read_data),
        .mem_addr   (mem_addr),
        .write_data (write_data)
    );
endmodule

//--- test/tb_programs.svh
// test program table, each program stores one word that is checked after halt
localparam int num_tests = 8;
localparam word_t halt_word = {op_halt, 13'h0000};

string prog_name [num_tests];
word_t prog_code [num_tests][16];
word_t prog_data [num_tests];       // preloaded at address 200
int prog_addr [num_tests];          // where the result lands
word_t prog_expect [num_tests];

function automatic word_t mov_imm(input int rn, input int imm8);
    return {op_move, 2'b10, rn[2:0], imm8[7:0]};
endfunction

// alu and mov register forms, rm shifted by sh
function automatic word_t reg_instr(input opcode_e opc, input int op, input int rn,
                                    input int rd, input int sh, input int rm);
    return {opc, op[1:0], rn[2:0], rd[2:0], sh[1:0], rm[2:0]};
endfunction

function automatic word_t mem_instr(input opcode_e opc, input int rn, input int rd,
                                    input int imm5);
    return {opc, 2'b00, rn[2:0], rd[2:0], imm5[4:0]};
endfunction

task automatic add_test(input int t, input string name, input word_t code [8],
                        input word_t data, input int addr, input word_t exp_word);
    prog_name[t] = name;
    for (int i = 0; i < 16; i++) begin
        prog_code[t][i] = halt_word;
    end
    for (int i = 0; i < 8; i++) begin
        prog_code[t][i] = code[i];
    end
    prog_data[t] = data;
    prog_addr[t] = addr;
    prog_expect[t] = exp_word;
endtask

task automatic build_programs();
    add_test(0, "mov_imm_pos",
             '{mov_imm(7, 'h64), mov_imm(1, 'h35), mem_instr(op_str, 7, 1, 0),
               halt_word, halt_word, halt_word, halt_word, halt_word}, 16'h0000, 100, 16'h0035);
    add_test(1, "mov_imm_neg",
             '{mov_imm(7, 'h64), mov_imm(1, 'hf3), mem_instr(op_str, 7, 1, 0),
               halt_word, halt_word, halt_word, halt_word, halt_word}, 16'h0000, 100, 16'hfff3);
    add_test(2, "add_lsl",
             '{mov_imm(7, 'h64), mov_imm(1, 'h23), mov_imm(2, 'h41),
               reg_instr(op_alu, 0, 1, 3, 1, 2), mem_instr(op_str, 7, 3, 0),
               halt_word, halt_word, halt_word}, 16'h0000, 100, 16'h00a5);
    add_test(3, "and_lsr",
             '{mov_imm(7, 'h64), mov_imm(1, 'hf3), mov_imm(2, 'h6c),
               reg_instr(op_alu, 2, 1, 3, 2, 2), mem_instr(op_str, 7, 3, 0),
               halt_word, halt_word, halt_word}, 16'h0000, 100, 16'h0032);
    add_test(4, "mvn_asr",
             '{mov_imm(7, 'h64), mov_imm(2, 'h90), reg_instr(op_alu, 3, 2, 3, 3, 2),
               mem_instr(op_str, 7, 3, 0),
               halt_word, halt_word, halt_word, halt_word}, 16'h0000, 100, 16'h0037);
    // add first leaves 0x11 in A, mov must not pick it up
    add_test(5, "mov_reg_lsl",
             '{mov_imm(7, 'h64), mov_imm(1, 'h11), mov_imm(2, 'h2a),
               reg_instr(op_alu, 0, 1, 3, 0, 2), reg_instr(op_move, 0, 0, 4, 1, 2),
               mem_instr(op_str, 7, 4, 0), halt_word, halt_word}, 16'h0000, 100, 16'h0054);
    add_test(6, "ldr_pos_offset",
             '{mov_imm(1, 'h61), reg_instr(op_move, 0, 0, 2, 1, 1), mem_instr(op_ldr, 2, 3, 6),
               mov_imm(7, 'h64), mem_instr(op_str, 7, 3, 0),
               halt_word, halt_word, halt_word}, 16'hbeef, 100, 16'hbeef);
    add_test(7, "ldr_neg_offset",
             '{mov_imm(1, 'h68), reg_instr(op_move, 0, 0, 2, 1, 1),
               mem_instr(op_ldr, 2, 3, 'h18), mov_imm(7, 'h60), mem_instr(op_str, 7, 3, 4),
               halt_word, halt_word, halt_word}, 16'h8421, 100, 16'h8421);
endtask

//--- test/tb_cpu.sv
// testbench for the multicycle cpu, runs the table programs and checks stored words
`timescale 1ns/1ns
module tb_cpu;
    import cpu_pkg::*;

    localparam int addr_width = 9;
    localparam int max_cycles = 500;

    logic clk;
    logic reset;
    word_t read_data;
    mem_cmd_e mem_cmd;
    logic [addr_width-1:0] mem_addr;
    word_t write_data;
    logic halted;

    word_t mem [512];
    logic wr_pending;
    logic [addr_width-1:0] wr_addr;
    word_t wr_data;
    int pass_count;
    int fail_count;
    int seed = 32'hff6a42e0;

    `include "tb_programs.svh"

    cpu_top #(
        .addr_width (addr_width)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .read_data  (read_data),
        .mem_cmd    (mem_cmd),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .halted     (halted)
    );

    always #10 clk = ~clk;

    assign read_data = mem[mem_addr];   // combinational read

    always @(negedge clk) begin
        wr_pending = (mem_cmd == mem_write);  // store sampled mid cycle
        wr_addr = mem_addr;
        wr_data = write_data;
    end

    always @(posedge clk) begin
        if (wr_pending) begin
            mem[wr_addr] = wr_data;
        end
    end

    task automatic load_program(input int t);
        for (int i = 0; i < 512; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            mem[i] = prog_code[t][i];
        end
        mem[200] = prog_data[t];
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #2 reset = 1'b1;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
    endtask

    task automatic wait_for_halt(output bit done);
        int cycles;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < max_cycles) begin
            @(negedge clk);
            done = (halted === 1'b1);
            cycles++;
        end
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            fail_count++;
        end
        if (actual === expected) begin
            $display("[PASS] %s", name);
            pass_count++;
        end
    endtask

    task automatic hold_after_halt();
        bit held;
        held = 1'b1;
        for (int i = 0; i < 20 && held; i++) begin
            @(negedge clk);
            held = (halted === 1'b1) && (mem_cmd === mem_none);
        end
        assert (held) else begin
            $display("[FAIL] halt_hold expected halted 1 cmd %0d actual halted %b cmd %0d",
                     mem_none, halted, mem_cmd);
            fail_count++;
        end
        if (held) begin
            $display("[PASS] halt_hold");
            pass_count++;
        end
    endtask

    task automatic restart_after_reset();
        int cycles;
        cycles = 0;
        reset_dut();
        @(negedge clk);
        compare_word("restart_halted", '0, word_t'(halted));
        while (mem_cmd !== mem_read && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (mem_cmd !== mem_read) begin
            $display("restart_fetch: no instruction fetch within 10 cycles after reset");
            fail_count++;
        end else begin
            compare_word("restart_fetch", '0, word_t'(mem_addr));
        end
    endtask

    initial begin
        bit done;
        clk = 1'b0;
        reset = 1'b1;
        pass_count = 0;
        fail_count = 0;
        build_programs();
        for (int t = 0; t < num_tests; t++) begin
            load_program(t);
            reset_dut();
            wait_for_halt(done);
            if (done) begin
                compare_word(prog_name[t], prog_expect[t], mem[prog_addr[t]]);
            end else begin
                $display("%s: cpu did not halt within %0d cycles", prog_name[t], max_cycles);
                fail_count++;
            end
        end
        hold_after_halt();
        restart_after_reset();
        $display("tests %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

//--- src.f
+incdir+test
logic/cpu_pkg.sv
logic/ctrl_if.sv
logic/instruction_decoder.sv
logic/control_sequencer.sv
logic/datapath.sv
logic/cpu_top.sv
test/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build the cpu testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f src.f -o tb_cpu
./obj_dir/tb_cpu > sim.log
cat sim.log
if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
